// ==== filelist.f ====
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/int_alu.sv
rtl/iter_counter.sv
rtl/muldiv_unit.sv
rtl/reg_file.sv
rtl/issue_fsm.sv
rtl/exec_core.sv
verification/exec_core_tb.sv

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;   // byte address
        logic [31:0] dat;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    localparam logic [7:0] ADR_ISSUE    = 8'h00;
    localparam logic [7:0] ADR_REG_BASE = 8'h80;  // x[r] at base + 4r

endpackage

`default_nettype wire

// ==== rtl/exec_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_core import isa_pkg::*, bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    xlen_t    wr_data;
    alu_op_e  alu_op;
    xlen_t    alu_b;
    xlen_t    alu_result;
    logic     md_start;
    logic     md_step;
    md_op_e   md_op;
    xlen_t    md_result;
    logic     cnt_load;
    logic     cnt_done;

    issue_fsm u_issue_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .alu_op     (alu_op),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .md_start   (md_start),
        .md_step    (md_step),
        .md_op      (md_op),
        .md_result  (md_result),
        .cnt_load   (cnt_load),
        .cnt_done   (cnt_done)
    );

    iter_counter u_iter_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (cnt_load),
        .done  (cnt_done)
    );

    int_alu u_int_alu (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
    );

    muldiv_unit u_muldiv_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (md_start),
        .step   (md_step),
        .op     (md_op),
        .a      (rs1_data),
        .b      (rs2_data),
        .result (md_result)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_alu import isa_pkg::*; (
    input  alu_op_e op,
    input  xlen_t   a,
    input  xlen_t   b,
    output xlen_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one issued word, seen as R or I
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        xlen_t  raw;
    } instr_u;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // M extension, funct7 = F7_MULDIV
    localparam logic [2:0] F3_MUL   = 3'b000;
    localparam logic [2:0] F3_MULHU = 3'b011;
    localparam logic [2:0] F3_DIV   = 3'b100;
    localparam logic [2:0] F3_DIVU  = 3'b101;
    localparam logic [2:0] F3_REM   = 3'b110;
    localparam logic [2:0] F3_REMU  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        MD_MUL, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } md_op_e;

endpackage

`default_nettype wire

// ==== rtl/issue_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_fsm import isa_pkg::*, bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output xlen_t    wr_data,
    output alu_op_e  alu_op,
    output xlen_t    alu_b,
    input  xlen_t    alu_result,
    output logic     md_start,
    output logic     md_step,
    output md_op_e   md_op,
    input  xlen_t    md_result,
    output logic     cnt_load,
    input  logic     cnt_done
);

    typedef enum logic [2:0] {S_IDLE, S_ALU_WB, S_MD_BUSY, S_MD_WB, S_RESP} state_e;

    state_e   state;
    state_e   state_nxt;
    instr_u   ins;
    logic     req;
    logic     is_issue;
    logic     in_reg_win;
    logic [7:0] reg_off;
    xlen_t    imm_sext;
    logic     dec_ok;
    logic     dec_md;
    logic     dec_imm;
    alu_op_e  dec_alu;
    md_op_e   dec_md_op;
    logic     ack_q;
    logic     err_q;
    xlen_t    dat_q;
    xlen_t    res_q;
    reg_idx_t rd_q;

    assign ins.raw    = wb_req.dat;
    assign req        = wb_req.cyc && wb_req.stb && (state == S_IDLE);
    assign is_issue   = wb_req.we && (wb_req.adr == ADR_ISSUE);
    assign in_reg_win = (wb_req.adr >= ADR_REG_BASE) && (wb_req.adr[1:0] == 2'b00);
    assign reg_off    = wb_req.adr - ADR_REG_BASE;
    assign imm_sext   = {{20{ins.i.imm12[11]}}, ins.i.imm12};

    always_comb begin
        dec_ok    = 1'b0;
        dec_md    = 1'b0;
        dec_imm   = 1'b0;
        dec_alu   = ALU_ADD;
        dec_md_op = MD_MUL;
        case (opcode_e'(ins.r.opcode))
            OPC_OP: begin
                dec_ok = 1'b1;
                dec_md = (ins.r.funct7 == F7_MULDIV);
                case ({ins.r.funct7, ins.r.funct3})
                    {F7_BASE, F3_ADD_SUB}: dec_alu = ALU_ADD;
                    {F7_ALT, F3_ADD_SUB}:  dec_alu = ALU_SUB;
                    {F7_BASE, F3_SLL}:     dec_alu = ALU_SLL;
                    {F7_BASE, F3_SLT}:     dec_alu = ALU_SLT;
                    {F7_BASE, F3_SLTU}:    dec_alu = ALU_SLTU;
                    {F7_BASE, F3_XOR}:     dec_alu = ALU_XOR;
                    {F7_BASE, F3_SR}:      dec_alu = ALU_SRL;
                    {F7_ALT, F3_SR}:       dec_alu = ALU_SRA;
                    {F7_BASE, F3_OR}:      dec_alu = ALU_OR;
                    {F7_BASE, F3_AND}:     dec_alu = ALU_AND;
                    {F7_MULDIV, F3_MUL}:   dec_md_op = MD_MUL;
                    {F7_MULDIV, F3_MULHU}: dec_md_op = MD_MULHU;
                    {F7_MULDIV, F3_DIV}:   dec_md_op = MD_DIV;
                    {F7_MULDIV, F3_DIVU}:  dec_md_op = MD_DIVU;
                    {F7_MULDIV, F3_REM}:   dec_md_op = MD_REM;
                    {F7_MULDIV, F3_REMU}:  dec_md_op = MD_REMU;
                    default:               dec_ok = 1'b0;  // mulh, mulhsu land here too
                endcase
            end
            OPC_OP_IMM: begin
                dec_ok  = 1'b1;
                dec_imm = 1'b1;
                case (ins.i.funct3)
                    F3_ADD_SUB: dec_alu = ALU_ADD;
                    F3_SLT:     dec_alu = ALU_SLT;
                    F3_SLTU:    dec_alu = ALU_SLTU;
                    F3_XOR:     dec_alu = ALU_XOR;
                    F3_OR:      dec_alu = ALU_OR;
                    F3_AND:     dec_alu = ALU_AND;
                    F3_SLL: begin
                        dec_alu = ALU_SLL;
                        dec_ok  = (ins.r.funct7 == F7_BASE);
                    end
                    F3_SR: begin
                        // upper imm bits read through the R view
                        dec_alu = (ins.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        dec_ok  = (ins.r.funct7 == F7_BASE) || (ins.r.funct7 == F7_ALT);
                    end
                endcase
            end
            default: dec_ok = 1'b0;
        endcase
    end

    // rs1 port doubles as the host readback port
    assign rs1_idx  = is_issue ? ins.r.rs1 : reg_off[6:2];
    assign rs2_idx  = ins.r.rs2;
    assign alu_op   = dec_alu;
    assign alu_b    = dec_imm ? imm_sext : rs2_data;
    assign md_op    = dec_md_op;
    assign md_start = req && is_issue && dec_ok && dec_md;
    assign cnt_load = md_start;
    assign md_step  = (state == S_MD_BUSY) && !cnt_done;
    assign wr_en    = (state == S_ALU_WB) || (state == S_MD_WB);
    assign wr_idx   = rd_q;
    assign wr_data  = (state == S_MD_WB) ? md_result : res_q;
    assign wb_rsp   = '{ack: ack_q, err: err_q, dat: dat_q};

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (req && is_issue && dec_ok) begin
                    state_nxt = dec_md ? S_MD_BUSY : S_ALU_WB;
                end else if (req) begin
                    state_nxt = S_RESP;
                end
            end
            S_MD_BUSY: begin
                if (cnt_done) begin
                    state_nxt = S_MD_WB;
                end
            end
            default: state_nxt = S_IDLE;  // wb and resp last one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (req) begin
                if (is_issue) begin
                    ack_q <= dec_ok && !dec_md;
                    err_q <= !dec_ok;
                end else if (in_reg_win && !wb_req.we) begin
                    ack_q <= 1'b1;
                end else begin
                    err_q <= 1'b1;
                end
            end
            if ((state == S_MD_BUSY) && cnt_done) begin
                ack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_q <= rs1_data;
            res_q <= alu_result;  // alu runs in the decode cycle
            rd_q  <= ins.r.rd;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/iter_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module iter_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    output logic done
);

    localparam logic [5:0] ITERS = 6'd32;  // one per operand bit

    logic [5:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                cnt <= ITERS;
            end else if (cnt != '0) begin
                cnt  <= cnt - 6'd1;
                done <= (cnt == 6'd1);  // pulse as it hits zero
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit import isa_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   step,
    input  md_op_e op,
    input  xlen_t  a,
    input  xlen_t  b,
    output xlen_t  result
);

    md_op_e      op_q;
    xlen_t       opnd_q;    // multiplicand, or divisor magnitude
    logic [63:0] acc;       // {hi, lo}; lo starts as multiplier or dividend
    logic        q_neg;
    logic        r_neg;
    logic        step_q;
    logic        is_mul;
    logic        is_sdiv;
    xlen_t       a_mag;
    xlen_t       b_mag;
    logic [32:0] mul_sum;
    logic [32:0] rem_sh;
    logic        sub_ok;
    xlen_t       final_res;

    assign is_mul  = (op == MD_MUL) || (op == MD_MULHU);
    assign is_sdiv = (op == MD_DIV) || (op == MD_REM);
    assign a_mag   = (is_sdiv && a[31]) ? -a : a;
    assign b_mag   = (is_sdiv && b[31]) ? -b : b;

    assign mul_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opnd_q} : 33'd0);
    assign rem_sh  = acc[63:31];
    assign sub_ok  = (rem_sh >= {1'b0, opnd_q});

    always_ff @(posedge clk) begin
        if (start) begin
            op_q   <= op;
            opnd_q <= is_mul ? a : b_mag;
            acc    <= {32'd0, (is_mul ? b : a_mag)};
            // div by zero keeps quotient all ones
            q_neg  <= is_sdiv && (a[31] ^ b[31]) && (b != '0);
            r_neg  <= is_sdiv && a[31];
        end else if (step) begin
            if ((op_q == MD_MUL) || (op_q == MD_MULHU)) begin
                acc <= {mul_sum, acc[31:1]};  // shift-add
            end else if (sub_ok) begin
                acc <= {rem_sh[31:0] - opnd_q, acc[30:0], 1'b1};
            end else begin
                acc <= {rem_sh[31:0], acc[30:0], 1'b0};  // restore
            end
        end
    end

    // most-negative / -1 falls out of the sign fix
    always_comb begin
        case (op_q)
            MD_MUL:          final_res = acc[31:0];
            MD_MULHU:        final_res = acc[63:32];
            MD_DIV, MD_DIVU: final_res = q_neg ? -acc[31:0] : acc[31:0];
            default:         final_res = r_neg ? -acc[63:32] : acc[63:32];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step;
        end
    end

    always_ff @(posedge clk) begin
        if (step_q && !step) begin
            result <= final_res;  // after the last step
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);

    xlen_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is never written, so it stays zero
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

`default_nettype wire

// ==== verification/exec_core_stim.txt ====
# I adr word: issue, expect ack | E adr word: bus write, expect err
# R reg value: read register, expect value (all fields hex)
R 00 00000000
R 1f 00000000
I 00 00500013
R 00 00000000
I 00 06400093
I 00 ff900113
R 01 00000064
R 02 fffffff9
I 00 402081b3
I 00 00409213
I 00 40115293
I 00 00115333
I 00 001123b3
I 00 00113433
I 00 fff0c493
I 00 00117533
I 00 001165b3
R 03 0000006b
R 04 00000640
R 05 fffffffc
R 06 0fffffff
R 07 00000001
R 08 00000000
R 09 ffffff9b
R 0a 00000060
R 0b fffffffd
I 00 02110633
I 00 021136b3
I 00 0220c733
I 00 0220e7b3
I 00 02115833
I 00 021178b3
I 00 02014933
I 00 020169b3
R 0c fffffd44
R 0d 00000063
R 0e fffffff2
R 0f 00000002
R 10 028f5c28
R 11 00000059
R 12 ffffffff
R 13 fffffff9
I 00 01f39a13
I 00 fff00a93
I 00 035a4b33
I 00 035a6bb3
R 14 80000000
R 15 ffffffff
R 16 80000000
R 17 00000000
E 00 00000073
E 00 12345c37
E 00 40109c33
E 00 02109c33
E 84 00000005
E 04 00000013
R 18 00000000
R 01 00000064

// ==== verification/exec_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_core_tb import isa_pkg::*, bus_pkg::*; ();

    localparam int N_RAND   = 4;
    localparam int RAND_OPS = 18;  // bus transfers per random case
    localparam int N_REGS   = 32;

    localparam wb_rsp_t RSP_ACK = '{ack: 1'b1, err: 1'b0, dat: 32'd0};
    localparam wb_rsp_t RSP_ERR = '{ack: 1'b0, err: 1'b1, dat: 32'd0};

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    int      cycles = 0;
    int      limit = 100000;
    integer  seed = 32'h5ca7;

    logic [7:0] stim_cmd [$];
    xlen_t      stim_a [$];
    xlen_t      stim_b [$];

    exec_core exec_core_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
        end
    endtask

    // response kind only, read data goes through check_word
    task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
        if ({got.ack, got.err} !== {exp.ack, exp.err}) begin
            abort_run($sformatf("CHECK FAILED: %s ack/err got %h expected %h",
                                name, {got.ack, got.err}, {exp.ack, exp.err}));
        end
    endtask

    task automatic bus_xfer(input logic we, input logic [7:0] adr, input xlen_t dat,
                            output wb_rsp_t rsp);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
        end while (!(wb_rsp.ack || wb_rsp.err));
        rsp = wb_rsp;
        @(posedge clk);
        wb_req <= '0;  // stb drops the cycle after the response
    endtask

    task automatic write_expect(input logic [7:0] adr, input xlen_t dat, input wb_rsp_t exp);
        wb_rsp_t rsp;
        bus_xfer(1'b1, adr, dat, rsp);
        check_rsp($sformatf("wb_rsp for write %h at %h", dat, adr), rsp, exp);
    endtask

    task automatic read_expect(input reg_idx_t idx, input xlen_t exp);
        wb_rsp_t rsp;
        bus_xfer(1'b0, ADR_REG_BASE + {1'b0, idx, 2'b00}, '0, rsp);
        check_rsp($sformatf("wb_rsp for read of x%0d", idx), rsp, RSP_ACK);
        check_word($sformatf("x%0d", idx), rsp.dat, exp);
    endtask

    // every register comes out of reset as zero
    task automatic expect_regs_cleared();
        for (int r = 0; r < N_REGS; r++) begin
            read_expect(reg_idx_t'(r), '0);
        end
    endtask

    function automatic xlen_t enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic xlen_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // no lui here, so build the word from ori and slli pieces
    task automatic load_reg(input reg_idx_t rd, input xlen_t val);
        write_expect(ADR_ISSUE, enc_i(F3_OR, rd, 5'd0, {1'b0, val[31:21]}), RSP_ACK);
        write_expect(ADR_ISSUE, enc_i(F3_SLL, rd, rd, 12'd11), RSP_ACK);
        write_expect(ADR_ISSUE, enc_i(F3_OR, rd, rd, {1'b0, val[20:10]}), RSP_ACK);
        write_expect(ADR_ISSUE, enc_i(F3_SLL, rd, rd, 12'd10), RSP_ACK);
        write_expect(ADR_ISSUE, enc_i(F3_OR, rd, rd, {2'b00, val[9:0]}), RSP_ACK);
    endtask

    task automatic run_random_cases();
        xlen_t       a;
        xlen_t       b;
        logic [63:0] prod;
        for (int k = 0; k < N_RAND; k++) begin
            a    = $random(seed);
            b    = $random(seed);
            prod = {32'd0, a} * {32'd0, b};
            load_reg(5'd25, a);
            load_reg(5'd26, b);
            write_expect(ADR_ISSUE, enc_r(F7_MULDIV, F3_MUL, 5'd27, 5'd25, 5'd26), RSP_ACK);
            write_expect(ADR_ISSUE, enc_r(F7_MULDIV, F3_MULHU, 5'd28, 5'd25, 5'd26), RSP_ACK);
            write_expect(ADR_ISSUE, enc_r(F7_MULDIV, F3_DIVU, 5'd29, 5'd25, 5'd26), RSP_ACK);
            read_expect(5'd25, a);
            read_expect(5'd26, b);
            read_expect(5'd27, prod[31:0]);
            read_expect(5'd28, prod[63:32]);
            read_expect(5'd29, (b == '0) ? 32'hffff_ffff : a / b);  // div by zero rule
        end
    endtask

    initial begin
        int         fd;
        int         n;
        string      line;
        logic [7:0] cmd;
        xlen_t      fa;
        xlen_t      fb;
        clk    = 1'b0;
        rst_n  = 1'b0;
        wb_req = '0;

        fd = $fopen("verification/exec_core_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if ((n > 0) && (line[0] != "#")) begin
                if ($sscanf(line, "%c %h %h", cmd, fa, fb) == 3) begin
                    stim_cmd.push_back(cmd);
                    stim_a.push_back(fa);
                    stim_b.push_back(fb);
                end
            end
        end
        $fclose(fd);
        if (stim_cmd.size() == 0) begin
            abort_run("stimulus file holds no commands");
        end
        limit = (stim_cmd.size() + N_REGS + N_RAND * RAND_OPS) * 40 + 100;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        expect_regs_cleared();
        foreach (stim_cmd[i]) begin
            case (stim_cmd[i])
                "I": write_expect(stim_a[i][7:0], stim_b[i], RSP_ACK);
                "E": write_expect(stim_a[i][7:0], stim_b[i], RSP_ERR);
                "R": read_expect(stim_a[i][4:0], stim_b[i]);
                default: abort_run($sformatf("unknown stimulus command %c", stim_cmd[i]));
            endcase
        end
        run_random_cases();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
